/* files.f */
+incdir+src
src/pctl_data_pkg.sv
src/pctl_ctrl_pkg.sv
src/event_decode.sv
src/event_sequencer.sv
src/sysreg_commit.sv
src/pipeline_control.sv
tb/pipeline_control_asserts.sv
tb/tb_pipeline_control.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ns -f files.f \
		--top-module tb_pipeline_control -Mdir obj_dir
	out=$$(./obj_dir/Vtb_pipeline_control +verilator+error+limit+100); \
		echo "$$out"; \
		echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* tb/tb_pipeline_control.sv */
`timescale 1ns/1ns
`include "pctl_cfg.svh"
`default_nettype none

module tb_pipeline_control
	import pctl_data_pkg::*;
	import pctl_ctrl_pkg::*;
();

	localparam int NUM_EVENTS = 18;

	logic iCLOCK;
	logic inRESET;
	logic reset_sync;
	logic branch_valid;
	logic reload_valid;
	logic return_valid;
	addr_t jump_addr;
	logic irq_req;
	logic irq_lock;
	irq_num_t irq_num;
	logic irq_ack;
	word_t sysreg_psr;
	word_t sysreg_pcr;
	word_t sysreg_ppcr;
	addr_t sysreg_idtr;
	logic ldst_valid;
	logic ldst_ready;
	addr_t ldst_addr;
	logic rsp_valid;
	word_t rsp_data;
	logic event_hold;
	logic event_start;
	logic event_irq_front2back;
	logic event_irq_back2front;
	logic event_end;
	logic pcr_set;
	word_t pcr;
	logic ppcr_set;
	word_t ppcr;

	int seed = 72;
	logic stall_load = 1'b0;

	pipeline_control uut (.*);

	bind pipeline_control pipeline_control_asserts u_asserts (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #2 iCLOCK = ~iCLOCK;
	end

	// Inputs change 1 ns after the rising edge
	task automatic wait_cycles(input int n);
		if (n > 0) begin
			repeat (n) @(posedge iCLOCK);
			#1;
		end
	endtask

	task automatic clear_requests();
		branch_valid = 1'b0;
		reload_valid = 1'b0;
		return_valid = 1'b0;
		irq_req = 1'b0;
		irq_lock = 1'b0;
	endtask

	task automatic load_regs(input logic irq_en);
		jump_addr = $random(seed);
		sysreg_pcr = $random(seed);
		sysreg_ppcr = $random(seed);
		sysreg_idtr = $random(seed);
		irq_num = irq_num_t'($random(seed));
		sysreg_psr = $random(seed);
		sysreg_psr[`PCTL_PSR_IRQ_EN_BIT] = irq_en;
	endtask

	task automatic wait_start();
		do begin
			wait_cycles(1);
		end while (!event_start);
	endtask

	task automatic wait_end();
		while (!event_end) begin
			wait_cycles(1);
		end
	endtask

	// Requests stay up until event_start
	task automatic run_event(input logic branch, input logic reload, input logic ret,
		input logic irq, input logic lock, input logic irq_en);
		load_regs(irq_en);
		branch_valid = branch;
		reload_valid = reload;
		return_valid = ret;
		irq_req = irq;
		irq_lock = lock;
		wait_start();
		clear_requests();
		// Registers move on while the event runs
		load_regs(irq_en);
		wait_end();
		wait_cycles(1);
	endtask

	// IDT load responder with random ready and response delays
	initial begin
		int delay;
		ldst_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp_data = '0;
		forever begin
			wait_cycles(1);
			if (ldst_valid && !stall_load) begin
				delay = $random(seed) & 3;
				wait_cycles(delay);
				ldst_ready = 1'b1;
				wait_cycles(1);
				ldst_ready = 1'b0;
				delay = $random(seed) & 3;
				wait_cycles(delay);
				rsp_valid = 1'b1;
				rsp_data = $random(seed);
				wait_cycles(1);
				rsp_valid = 1'b0;
			end
		end
	end

	always @(negedge iCLOCK) begin
		if (uut.u_asserts.error_count != 0) begin
			$display("*** FAILED ***");
			$fatal(1, "A bound assertion failed, see the Fail line above");
		end
	end

	initial begin
		repeat (200 * NUM_EVENTS) @(posedge iCLOCK);
		$display("*** FAILED ***");
		$fatal(1, "Watchdog timeout: the event sequence did not complete in time");
	end

	initial begin
		inRESET = 1'b0;
		reset_sync = 1'b0;
		clear_requests();
		load_regs(1'b0);
		wait_cycles(4);
		inRESET = 1'b1;
		wait_cycles(2);

		// Plain branches
		for (int i = 0; i < 2; i++) begin
			run_event(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		end
		// Interrupt calls, load port under random back-pressure
		for (int i = 0; i < 4; i++) begin
			run_event(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
		end

		// Priority and masking
		run_event(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
		run_event(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
		run_event(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1);
		run_event(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		run_event(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);

		for (int i = 0; i < 2; i++) begin
			run_event(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
		end

		// Branch raised while an interrupt call holds the pipeline
		load_regs(1'b1);
		irq_req = 1'b1;
		wait_start();
		irq_req = 1'b0;
		branch_valid = 1'b1;
		wait_end();
		wait_start();
		branch_valid = 1'b0;
		wait_end();
		wait_cycles(1);

		// reset_sync while the IDT fetch is stalled
		stall_load = 1'b1;
		load_regs(1'b1);
		irq_req = 1'b1;
		wait_start();
		irq_req = 1'b0;
		wait_cycles(3);
		reset_sync = 1'b1;
		wait_cycles(1);
		reset_sync = 1'b0;
		stall_load = 1'b0;
		wait_cycles(2);
		run_event(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1);
		run_event(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

		wait_cycles(4);
		if (uut.u_asserts.error_count == 0) begin
			$display("*** PASSED ***");
		end
		else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/pipeline_control_asserts.sv */
`timescale 1ns/1ns
`include "pctl_cfg.svh"
`default_nettype none

module pipeline_control_asserts
	import pctl_data_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	input logic branch_valid,
	input logic reload_valid,
	input logic irq_req,
	input logic irq_lock,
	input irq_num_t irq_num,
	input addr_t jump_addr,
	input word_t sysreg_psr,
	input word_t sysreg_pcr,
	input word_t sysreg_ppcr,
	input addr_t sysreg_idtr,
	input logic ldst_valid,
	input logic ldst_ready,
	input addr_t ldst_addr,
	input logic rsp_valid,
	input word_t rsp_data,
	input logic event_hold,
	input logic event_start,
	input logic event_irq_front2back,
	input logic event_irq_back2front,
	input logic event_end,
	input logic pcr_set,
	input word_t pcr,
	input logic ppcr_set,
	input word_t ppcr,
	input logic irq_ack
);

	int error_count = 0;

	// Request inputs as sampled on the acceptance edge
	logic p_branch;
	logic p_reload;
	logic p_irq_en;
	irq_num_t p_irq_num;
	addr_t p_jump;
	addr_t p_idtr;
	word_t p_pcr;
	word_t p_ppcr;

	// Reference event derived from the priority rules
	logic ref_irq;
	logic ref_ret;
	word_t ref_pcr;
	word_t ref_ppcr;
	addr_t ref_addr;

	// Expected values of the event in flight
	logic active;
	logic req_done;
	logic exp_irq;
	word_t exp_pcr;
	word_t exp_ppcr;
	addr_t exp_addr;
	word_t rsp_q;

	always_ff @(posedge iCLOCK) begin
		p_branch <= branch_valid;
		p_reload <= reload_valid;
		p_irq_en <= irq_req && !irq_lock && sysreg_psr[`PCTL_PSR_IRQ_EN_BIT];
		p_irq_num <= irq_num;
		p_jump <= jump_addr;
		p_idtr <= sysreg_idtr;
		p_pcr <= sysreg_pcr;
		p_ppcr <= sysreg_ppcr;
	end

	assign ref_irq = p_irq_en;
	assign ref_ret = !p_irq_en && !p_branch && !p_reload;
	assign ref_pcr = ref_ret ? p_ppcr : p_jump;
	assign ref_ppcr = p_branch ? p_jump : p_pcr;
	assign ref_addr = p_idtr + addr_t'(p_irq_num) * `PCTL_IDT_ENTRY_BYTES;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			active <= 1'b0;
			req_done <= 1'b0;
		end
		else if (reset_sync) begin
			active <= 1'b0;
			req_done <= 1'b0;
		end
		else begin
			if (event_start) begin
				active <= 1'b1;
			end
			else if (event_end) begin
				active <= 1'b0;
				req_done <= 1'b0;
			end
			if (ldst_valid && ldst_ready) begin
				req_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (event_start) begin
			exp_irq <= ref_irq;
			exp_pcr <= ref_pcr;
			exp_ppcr <= ref_ppcr;
			exp_addr <= ref_addr;
		end
		if (rsp_valid && req_done) begin
			rsp_q <= rsp_data;
		end
	end

	// Start strobes and the load request follow the event kind
	assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		event_start |-> event_hold && (event_irq_front2back == ref_irq)
			&& (event_irq_back2front == ref_ret) && (ldst_valid == ref_irq))
	else begin
		error_count++;
		$error("Fail %0t: wrong strobes or load request with event_start", $time);
	end

	// Short events write PCR one cycle after start
	assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		event_start && !ref_irq |=> pcr_set && event_end && !ppcr_set && !irq_ack
			&& (pcr == exp_pcr))
	else begin
		error_count++;
		$error("Fail %0t: short event commit wrong, pcr %h", $time, pcr);
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		ldst_valid |-> (event_start ? (ldst_addr == ref_addr)
			: (active && exp_irq && (ldst_addr == exp_addr))))
	else begin
		error_count++;
		$error("Fail %0t: load request wrong, addr %h", $time, ldst_addr);
	end

	// Request held under back-pressure
	assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		ldst_valid && !ldst_ready |=> ldst_valid && $stable(ldst_addr))
	else begin
		error_count++;
		$error("Fail %0t: load request dropped or changed while not ready", $time);
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		rsp_valid && req_done |=> event_end && pcr_set && ppcr_set && irq_ack
			&& (pcr == rsp_q) && (ppcr == exp_ppcr))
	else begin
		error_count++;
		$error("Fail %0t: interrupt commit wrong, pcr %h ppcr %h", $time, pcr, ppcr);
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		event_end || pcr_set || ppcr_set |-> event_end && pcr_set && active
			&& (ppcr_set == irq_ack) && (irq_ack == exp_irq))
	else begin
		error_count++;
		$error("Fail %0t: end strobes out of place", $time);
	end

	// Hold spans start up to end, one event at a time
	assert property (@(posedge iCLOCK) disable iff (!inRESET || reset_sync)
		(event_hold == (event_start || (active && !event_end)))
			&& !(event_start && active))
	else begin
		error_count++;
		$error("Fail %0t: event_hold %b outside the event window", $time, event_hold);
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		reset_sync |=> !(event_hold || event_start || event_end || pcr_set || ppcr_set
			|| irq_ack || ldst_valid || event_irq_front2back || event_irq_back2front))
	else begin
		error_count++;
		$error("Fail %0t: strobes not cleared by reset_sync", $time);
	end

endmodule

`default_nettype wire

/* src/pipeline_control.sv */
`timescale 1ns/1ns
`default_nettype none

module pipeline_control
	import pctl_data_pkg::*;
	import pctl_ctrl_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	// Execute stage
	input logic branch_valid,
	input logic reload_valid,
	input logic return_valid,
	input addr_t jump_addr,
	// Interrupt controller
	input logic irq_req,
	input logic irq_lock,
	input irq_num_t irq_num,
	output logic irq_ack,
	// System registers
	input word_t sysreg_psr,
	input word_t sysreg_pcr,
	input word_t sysreg_ppcr,
	input addr_t sysreg_idtr,
	// Load port
	output logic ldst_valid,
	input logic ldst_ready,
	output addr_t ldst_addr,
	input logic rsp_valid,
	input word_t rsp_data,
	// Core event strobes
	output logic event_hold,
	output logic event_start,
	output logic event_irq_front2back,
	output logic event_irq_back2front,
	output logic event_end,
	// Register writes
	output logic pcr_set,
	output word_t pcr,
	output logic ppcr_set,
	output word_t ppcr
);

	logic ev_valid;
	logic ev_ready;
	event_kind_t ev_kind;
	addr_t ev_target;
	irq_num_t ev_irq_num;

	logic commit_valid;
	event_kind_t commit_kind;
	word_t commit_pcr;
	word_t commit_ppcr;

	event_decode u_decode (
		.branch_valid(branch_valid),
		.reload_valid(reload_valid),
		.return_valid(return_valid),
		.jump_addr(jump_addr),
		.irq_req(irq_req),
		.irq_lock(irq_lock),
		.irq_num(irq_num),
		.sysreg_psr(sysreg_psr),
		.sysreg_ppcr(sysreg_ppcr),
		.ev_valid(ev_valid),
		.ev_kind(ev_kind),
		.ev_target(ev_target),
		.ev_irq_num(ev_irq_num)
	);

	// ev_ready gates acceptance, one event in flight
	event_sequencer u_sequencer (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.ev_valid(ev_valid),
		.ev_ready(ev_ready),
		.ev_kind(ev_kind),
		.ev_target(ev_target),
		.ev_irq_num(ev_irq_num),
		.sysreg_pcr(sysreg_pcr),
		.sysreg_idtr(sysreg_idtr),
		.event_hold(event_hold),
		.event_start(event_start),
		.event_irq_front2back(event_irq_front2back),
		.event_irq_back2front(event_irq_back2front),
		.ldst_valid(ldst_valid),
		.ldst_ready(ldst_ready),
		.ldst_addr(ldst_addr),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.commit_valid(commit_valid),
		.commit_kind(commit_kind),
		.commit_pcr(commit_pcr),
		.commit_ppcr(commit_ppcr)
	);

	sysreg_commit u_commit (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.reset_sync(reset_sync),
		.commit_valid(commit_valid),
		.commit_kind(commit_kind),
		.commit_pcr(commit_pcr),
		.commit_ppcr(commit_ppcr),
		.pcr_set(pcr_set),
		.pcr(pcr),
		.ppcr_set(ppcr_set),
		.ppcr(ppcr),
		.irq_ack(irq_ack),
		.event_end(event_end)
	);

endmodule

`default_nettype wire

/* src/sysreg_commit.sv */
`timescale 1ns/1ns
`include "pctl_cfg.svh"
`default_nettype none

module sysreg_commit
	import pctl_ctrl_pkg::*;
	import pctl_data_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	// Commit from the sequencer
	input logic commit_valid,
	input event_kind_t commit_kind,
	input word_t commit_pcr,
	input word_t commit_ppcr,
	// System register writes
	output logic pcr_set,
	output word_t pcr,
	output logic ppcr_set,
	output word_t ppcr,
	// Interrupt controller and core
	output logic irq_ack,
	output logic event_end
);

	logic irq_commit;
	logic pcr_wr;
	logic ppcr_wr;
	logic commit_q;
	logic irq_commit_q;

	assign irq_commit = is_irq_kind(commit_kind);
	assign pcr_wr = commit_valid && !reset_sync;
	assign ppcr_wr = pcr_wr && irq_commit;

	// One-cycle strobes after the commit
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			commit_q <= 1'b0;
			irq_commit_q <= 1'b0;
		end
		else if (reset_sync) begin
			commit_q <= 1'b0;
			irq_commit_q <= 1'b0;
		end
		else begin
			commit_q <= commit_valid;
			irq_commit_q <= commit_valid && irq_commit;
		end
	end

	// Values stay until the next write
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr <= `PCTL_PCR_RESET_VAL;
			ppcr <= `PCTL_PPCR_RESET_VAL;
		end
		else begin
			if (pcr_wr) begin
				pcr <= commit_pcr;
			end
			if (ppcr_wr) begin
				ppcr <= commit_ppcr;
			end
		end
	end

	// Every event ends with a PCR write
	assign pcr_set = commit_q;
	assign event_end = commit_q;

	// Only interrupt calls save the return point
	assign ppcr_set = irq_commit_q;
	assign irq_ack = irq_commit_q;

endmodule

`default_nettype wire

/* src/event_sequencer.sv */
`timescale 1ns/1ns
`include "pctl_cfg.svh"
`default_nettype none

module event_sequencer
	import pctl_data_pkg::*;
	import pctl_ctrl_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic reset_sync,
	// Event from decode
	input logic ev_valid,
	output logic ev_ready,
	input event_kind_t ev_kind,
	input addr_t ev_target,
	input irq_num_t ev_irq_num,
	// System registers
	input word_t sysreg_pcr,
	input addr_t sysreg_idtr,
	// Core event strobes
	output logic event_hold,
	output logic event_start,
	output logic event_irq_front2back,
	output logic event_irq_back2front,
	// IDT load port
	output logic ldst_valid,
	input logic ldst_ready,
	output addr_t ldst_addr,
	input logic rsp_valid,
	input word_t rsp_data,
	// Commit to the register stage
	output logic commit_valid,
	output event_kind_t commit_kind,
	output word_t commit_pcr,
	output word_t commit_ppcr
);

	seq_state_t state;
	seq_state_t state_next;
	logic accept;
	addr_t idt_entry_addr;

	// Captured at acceptance
	event_kind_t kind_q;
	addr_t target_q;
	word_t ret_pcr_q;
	addr_t ldst_addr_q;

	assign ev_ready = (state == S_IDLE);
	assign accept = ev_valid && ev_ready;

	// Entry address of the requested interrupt
	assign idt_entry_addr = sysreg_idtr
		+ (addr_t'(ev_irq_num) * addr_t'(`PCTL_IDT_ENTRY_BYTES));

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE: begin
				if (accept) begin
					state_next = is_irq_kind(ev_kind) ? S_FETCH_REQ : S_SHORT;
				end
			end
			S_SHORT: begin
				state_next = S_IDLE;
			end
			S_FETCH_REQ: begin
				if (ldst_ready) begin
					state_next = S_FETCH_WAIT;
				end
			end
			S_FETCH_WAIT: begin
				// Response counted only after the request handshake
				if (rsp_valid) begin
					state_next = S_IDLE;
				end
			end
			default: begin
				state_next = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= S_IDLE;
		end
		else if (reset_sync) begin
			state <= S_IDLE;
		end
		else begin
			state <= state_next;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			kind_q <= ev_kind;
			target_q <= ev_target;
			ret_pcr_q <= sysreg_pcr;
			ldst_addr_q <= idt_entry_addr;
		end
	end

	// Start strobes, one cycle after acceptance
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			event_start <= 1'b0;
			event_irq_front2back <= 1'b0;
			event_irq_back2front <= 1'b0;
		end
		else if (reset_sync) begin
			event_start <= 1'b0;
			event_irq_front2back <= 1'b0;
			event_irq_back2front <= 1'b0;
		end
		else begin
			event_start <= accept;
			event_irq_front2back <= accept && is_irq_kind(ev_kind);
			event_irq_back2front <= accept && (ev_kind == EV_RETURN);
		end
	end

	assign event_hold = (state != S_IDLE);

	// Address held in a register, stable under back-pressure
	assign ldst_valid = (state == S_FETCH_REQ);
	assign ldst_addr = ldst_addr_q;

	// One commit per event
	assign commit_valid = (state == S_SHORT) || ((state == S_FETCH_WAIT) && rsp_valid);
	assign commit_kind = kind_q;
	assign commit_pcr = (state == S_FETCH_WAIT) ? rsp_data : target_q;

	// Combined jump returns to the branch target, plain call to the interrupted PC
	assign commit_ppcr = (kind_q == EV_JUMP_IRQ) ? target_q : ret_pcr_q;

endmodule

`default_nettype wire

/* src/event_decode.sv */
`timescale 1ns/1ns
`include "pctl_cfg.svh"
`default_nettype none

module event_decode
	import pctl_data_pkg::*;
	import pctl_ctrl_pkg::*;
(
	// Execute stage requests
	input logic branch_valid,
	input logic reload_valid,
	input logic return_valid,
	input addr_t jump_addr,
	// Interrupt controller
	input logic irq_req,
	input logic irq_lock,
	input irq_num_t irq_num,
	// System registers
	input word_t sysreg_psr,
	input word_t sysreg_ppcr,
	// Offered event
	output logic ev_valid,
	output event_kind_t ev_kind,
	output addr_t ev_target,
	output irq_num_t ev_irq_num
);

	logic irq_enabled;

	// Interrupt taken only when unlocked and enabled in PSR
	assign irq_enabled = irq_req && !irq_lock && sysreg_psr[`PCTL_PSR_IRQ_EN_BIT];

	// Fixed priority, highest first
	always_comb begin
		ev_valid = 1'b1;
		ev_kind = EV_JUMP;
		ev_target = jump_addr;
		if (branch_valid && irq_enabled) begin
			ev_kind = EV_JUMP_IRQ;
		end
		else if (irq_enabled) begin
			// Target unused, handler comes from the IDT
			ev_kind = EV_IRQ;
		end
		else if (branch_valid) begin
			ev_kind = EV_JUMP;
		end
		else if (reload_valid) begin
			// Refetch from the execute stage address
			ev_kind = EV_RELOAD;
		end
		else if (return_valid) begin
			ev_kind = EV_RETURN;
			ev_target = sysreg_ppcr;
		end
		else begin
			ev_valid = 1'b0;
		end
	end

	assign ev_irq_num = irq_num;

endmodule

`default_nettype wire

/* src/pctl_ctrl_pkg.sv */
`default_nettype none

package pctl_ctrl_pkg;

	// Event kinds, encoding follows the core's event numbering
	typedef enum logic [2:0] {
		EV_JUMP_IRQ = 3'h1,
		EV_IRQ      = 3'h3,
		EV_JUMP     = 3'h2,
		EV_RELOAD   = 3'h6,
		EV_RETURN   = 3'h4
	} event_kind_t;

	typedef enum logic [2:0] {
		S_IDLE       = 3'h0,
		S_SHORT      = 3'h1,
		S_FETCH_REQ  = 3'h2,
		S_FETCH_WAIT = 3'h3
	} seq_state_t;

	// Kinds that go through the IDT fetch
	function automatic logic is_irq_kind(input event_kind_t kind);
		return (kind == EV_JUMP_IRQ) || (kind == EV_IRQ);
	endfunction

endpackage

`default_nettype wire

/* src/pctl_data_pkg.sv */
`include "pctl_cfg.svh"
`default_nettype none

package pctl_data_pkg;

	// Register and data word
	typedef logic [`PCTL_XLEN-1:0] word_t;

	// Byte address
	typedef logic [`PCTL_XLEN-1:0] addr_t;

	// Interrupt number
	typedef logic [`PCTL_IRQ_NUM_W-1:0] irq_num_t;

endpackage

`default_nettype wire

/* src/pctl_cfg.svh */
`ifndef PCTL_CFG_SVH
`define PCTL_CFG_SVH

// Data path and address width
`define PCTL_XLEN 32

// Interrupt number from the interrupt controller
`define PCTL_IRQ_NUM_W 7

// One IDT entry, handler address in the first word
`define PCTL_IDT_ENTRY_BYTES 8

// Interrupt enable in PSR
`define PCTL_PSR_IRQ_EN_BIT 2

// Power-on values of the committed registers
`define PCTL_PCR_RESET_VAL 32'h0000_0000
`define PCTL_PPCR_RESET_VAL 32'h0000_0000

`endif
